/* sources.f */
logic/mmu_pkg.sv
logic/mem_atom_pkg.sv
logic/mmu_ctrl_regs.sv
logic/mmu_tlb.sv
logic/mmu_pt_walk.sv
logic/mmu_top.sv
test/tb_clkgen.sv
test/tb_atom_mem.sv
test/tb_mmu_chk.sv
test/tb_mmu.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_mmu
FILELIST  ?= sources.f
LOG       ?= sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_mmu.sv */
`timescale 1ns/10ps

module tb_mmu;

   localparam int TIMEOUT_CYC = 200;

   logic clkrst_mem_clk;
   logic clkrst_mem_rst_n;
   logic lookup_valid;
   mmu_pkg::vpn_t lookup_vpn;
   logic lookup_ready;
   logic resp_valid;
   logic resp_fault;
   mmu_pkg::ppn_t resp_ppn;
   mmu_pkg::pte_flags_t resp_flags;
   logic [3:0] s_awaddr;
   logic s_awvalid;
   logic s_awready;
   logic [31:0] s_wdata;
   logic [3:0] s_wstrb;
   logic s_wvalid;
   logic s_wready;
   logic s_bvalid;
   logic [1:0] s_bresp;
   logic s_bready;
   logic [3:0] s_araddr;
   logic s_arvalid;
   logic s_arready;
   logic s_rvalid;
   logic [1:0] s_rresp;
   logic [31:0] s_rdata;
   logic s_rready;
   logic ptw2arb_valid;
   mem_atom_pkg::arb_opc_t ptw2arb_opcode;
   mem_atom_pkg::atom_addr_t ptw2arb_addr;
   mem_atom_pkg::atom_data_t ptw2arb_rdata;
   logic ptw2arb_rvalid;
   logic ptw2arb_stall;

   int n_val_err;
   int n_timeout;
   integer seed;

   tb_clkgen u_clkgen (.clkrst_mem_clk, .clkrst_mem_rst_n);

   tb_atom_mem u_mem (
      .clkrst_mem_clk, .clkrst_mem_rst_n,
      .ptw2arb_valid, .ptw2arb_addr, .ptw2arb_rdata, .ptw2arb_rvalid, .ptw2arb_stall
   );

   mmu_top #(
      .TLB_ENTRIES(4),
      .CSR_ADDR_W(4)
   ) u_mmu_top (.*);

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
         n_val_err++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      n_timeout++;
   endtask

   // Translation the page tables in memory should give
   function automatic void expected_xlate(input mmu_pkg::vpn_t vpn, output mmu_pkg::ppn_t ppn,
                                          output mmu_pkg::pte_flags_t flags, output logic fault);
      logic [9:0] d;
      logic [9:0] t;
      d = vpn[19:10];
      t = vpn[9:0];
      ppn = '0;
      flags = '0;
      fault = 1'b0;
      if (d[1:0] == 2'd3) begin
         fault = 1'b1;
      end else if (d[1:0] == 2'd2) begin
         ppn = {d ^ 10'h2aa, t};
         flags = 4'b0011;
      end else if (t[2:0] == 3'd7) begin
         fault = 1'b1;
      end else begin
         ppn = {d, 10'h000} + {10'h000, t} + 20'h12345;
         flags = 4'b0011;
      end
   endfunction

   task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      int cyc;
      logic aw_done;
      logic w_done;
      resp = 2'b11;
      @(posedge clkrst_mem_clk);
      s_awaddr <= addr;
      s_awvalid <= 1'b1;
      s_wdata <= data;
      s_wstrb <= 4'hf;
      s_wvalid <= 1'b1;
      s_bready <= 1'b0;
      aw_done = 1'b0;
      w_done = 1'b0;
      cyc = 0;
      while (!(aw_done && w_done) && cyc < TIMEOUT_CYC) begin
         @(posedge clkrst_mem_clk);
         cyc++;
         if (!aw_done && s_awready) begin
            aw_done = 1'b1;
            s_awvalid <= 1'b0;
         end
         if (!w_done && s_wready) begin
            w_done = 1'b1;
            s_wvalid <= 1'b0;
         end
      end
      if (!(aw_done && w_done)) report_timeout("write address and data");
      // Hold bready low for one cycle of bvalid
      cyc = 0;
      while (!s_bvalid && cyc < TIMEOUT_CYC) begin
         @(posedge clkrst_mem_clk);
         cyc++;
      end
      s_bready <= 1'b1;
      @(posedge clkrst_mem_clk);
      if (s_bvalid) resp = s_bresp;
      else report_timeout("write response");
      s_bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int cyc;
      logic done;
      data = '0;
      resp = 2'b11;
      @(posedge clkrst_mem_clk);
      s_araddr <= addr;
      s_arvalid <= 1'b1;
      s_rready <= 1'b0;
      done = 1'b0;
      cyc = 0;
      while (!done && cyc < TIMEOUT_CYC) begin
         @(posedge clkrst_mem_clk);
         cyc++;
         if (s_arready) begin
            done = 1'b1;
            s_arvalid <= 1'b0;
         end
      end
      if (!done) report_timeout("read address");
      cyc = 0;
      while (!s_rvalid && cyc < TIMEOUT_CYC) begin
         @(posedge clkrst_mem_clk);
         cyc++;
      end
      s_rready <= 1'b1;
      @(posedge clkrst_mem_clk);
      if (s_rvalid) begin
         data = s_rdata;
         resp = s_rresp;
      end else begin
         report_timeout("read data");
      end
      s_rready <= 1'b0;
   endtask

   // One lookup with its latency counted from the accepting edge
   task automatic do_lookup(input mmu_pkg::vpn_t vpn, output mmu_pkg::ppn_t ppn,
                            output mmu_pkg::pte_flags_t flags, output logic fault,
                            output int lat, output logic walked);
      int cyc;
      logic done;
      ppn = '0;
      flags = '0;
      fault = 1'b0;
      walked = 1'b0;
      @(posedge clkrst_mem_clk);
      lookup_vpn <= vpn;
      lookup_valid <= 1'b1;
      done = 1'b0;
      cyc = 0;
      while (!done && cyc < TIMEOUT_CYC) begin
         @(posedge clkrst_mem_clk);
         cyc++;
         if (lookup_ready) begin
            done = 1'b1;
            lookup_valid <= 1'b0;
         end
      end
      if (!done) report_timeout("lookup acceptance");
      done = 1'b0;
      lat = 0;
      while (!done && lat < TIMEOUT_CYC) begin
         @(posedge clkrst_mem_clk);
         lat++;
         if (ptw2arb_valid) begin
            walked = 1'b1;
            // Page-table walks only ever read
            check_value($sformatf("vpn %05h arb opcode", vpn),
                        32'(mem_atom_pkg::ARB_OPC_READ), 32'(ptw2arb_opcode));
         end
         if (resp_valid) begin
            done = 1'b1;
            ppn = resp_ppn;
            flags = resp_flags;
            fault = resp_fault;
         end
      end
      if (!done) report_timeout("lookup response");
   endtask

   task automatic check_lookup(input string name, input mmu_pkg::vpn_t vpn,
                               output int lat, output logic walked);
      mmu_pkg::ppn_t ppn;
      mmu_pkg::ppn_t exp_ppn;
      mmu_pkg::pte_flags_t flags;
      mmu_pkg::pte_flags_t exp_flags;
      logic fault;
      logic exp_fault;
      do_lookup(vpn, ppn, flags, fault, lat, walked);
      expected_xlate(vpn, exp_ppn, exp_flags, exp_fault);
      check_value($sformatf("%s vpn %05h fault", name, vpn), 32'(exp_fault), 32'(fault));
      if (!exp_fault) begin
         check_value($sformatf("%s vpn %05h ppn", name, vpn), 32'(exp_ppn), 32'(ppn));
         check_value($sformatf("%s vpn %05h flags", name, vpn), 32'(exp_flags), 32'(flags));
      end
   endtask

   task automatic check_hit(input string name, input mmu_pkg::vpn_t vpn);
      int lat;
      logic walked;
      check_lookup(name, vpn, lat, walked);
      check_value({name, " latency"}, 32'd1, 32'(lat));
      check_value({name, " walk"}, 32'd0, 32'(walked));
   endtask

   task automatic check_miss(input string name, input mmu_pkg::vpn_t vpn);
      int lat;
      logic walked;
      check_lookup(name, vpn, lat, walked);
      check_value({name, " walk"}, 32'd1, 32'(walked));
   endtask

   initial begin
      logic [31:0] rdata;
      logic [1:0] resp;
      logic [31:0] rnd;
      mmu_pkg::vpn_t tlb_vpn [5];
      int lat;
      logic walked;
      int cyc;
      n_val_err = 0;
      n_timeout = 0;
      seed = 32'hfc6d_3475;
      lookup_valid = 1'b0;
      lookup_vpn = '0;
      s_awaddr = '0;
      s_awvalid = 1'b0;
      s_wdata = '0;
      s_wstrb = '0;
      s_wvalid = 1'b0;
      s_bready = 1'b0;
      s_araddr = '0;
      s_arvalid = 1'b0;
      s_rready = 1'b0;
      tlb_vpn[0] = {10'd8, 10'h001};
      tlb_vpn[1] = {10'd9, 10'h002};
      tlb_vpn[2] = {10'd10, 10'h003};
      tlb_vpn[3] = {10'd12, 10'h004};
      tlb_vpn[4] = {10'd13, 10'h005};
      cyc = 0;
      while (!clkrst_mem_rst_n && cyc < TIMEOUT_CYC) begin
         @(posedge clkrst_mem_clk);
         cyc++;
      end
      if (!clkrst_mem_rst_n) report_timeout("reset release");

      // Register block
      axi_write(4'h0, 32'h0000_0100, resp);
      check_value("pagedir write resp", 32'd0, 32'(resp));
      axi_read(4'h0, rdata, resp);
      check_value("pagedir readback", 32'h0000_0100, rdata);
      check_value("pagedir read resp", 32'd0, 32'(resp));
      axi_read(4'h8, rdata, resp);
      check_value("unknown offset read resp", 32'd2, 32'(resp));

      // Small pages, large pages, faults
      check_lookup("small", {10'd0, 10'd5}, lat, walked);
      check_lookup("small", {10'd1, 10'h123}, lat, walked);
      check_lookup("small", {10'd4, 10'h3fe}, lat, walked);
      check_lookup("small", {10'h101, 10'h010}, lat, walked);
      check_lookup("large", {10'd2, 10'h155}, lat, walked);
      check_lookup("large", {10'd6, 10'h000}, lat, walked);
      check_lookup("large", {10'h3fe, 10'h3ff}, lat, walked);
      check_lookup("dir fault", {10'd3, 10'd5}, lat, walked);
      check_lookup("tab fault", {10'd0, 10'd7}, lat, walked);
      check_lookup("tab fault", {10'h0f5, 10'h12f}, lat, walked);
      for (int i = 0; i < 16; i++) begin
         rnd = $random(seed);
         check_lookup("random", rnd[19:0], lat, walked);
      end

      // Start the TLB checks from an empty cache
      axi_write(4'h4, 32'h1, resp);
      check_value("flush write resp", 32'd0, 32'(resp));
      check_miss("tlb first", tlb_vpn[0]);
      check_hit("tlb repeat", tlb_vpn[0]);
      for (int i = 1; i < 5; i++) begin
         check_miss("tlb fill", tlb_vpn[i]);
      end
      check_hit("tlb newest", tlb_vpn[4]);
      check_hit("tlb older", tlb_vpn[3]);
      check_miss("tlb evicted", tlb_vpn[0]);

      // Flush forces a new walk with the same result
      axi_write(4'h4, 32'h1, resp);
      check_value("flush write resp", 32'd0, 32'(resp));
      check_miss("after flush", tlb_vpn[3]);
      check_hit("after refill", tlb_vpn[3]);

      $display("Errors: %0d value mismatches, %0d timeouts", n_val_err, n_timeout);
      if (n_val_err == 0 && n_timeout == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* test/tb_mmu_chk.sv */
`timescale 1ns/10ps

module tb_mmu_chk (
   input logic                     clkrst_mem_clk,
   input logic                     clkrst_mem_rst_n,
   input logic                     lookup_valid,
   input logic                     lookup_ready,
   input logic                     resp_valid,
   input logic                     tlb2ptw_done,
   input logic                     ptw2arb_valid,
   input logic                     ptw2arb_stall,
   input mem_atom_pkg::atom_addr_t ptw2arb_addr,
   input logic                     s_bvalid,
   input logic                     s_bready,
   input logic [1:0]               s_bresp,
   input logic                     s_rvalid,
   input logic                     s_rready,
   input logic [1:0]               s_rresp,
   input logic [31:0]              s_rdata
);

   logic wait_resp;
   logic [7:0] wait_cnt;

   // Cycles since the last accepted lookup
   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         wait_resp <= 1'b0;
         wait_cnt <= '0;
      end else if (resp_valid) begin
         wait_resp <= 1'b0;
         wait_cnt <= '0;
      end else if (lookup_valid && lookup_ready) begin
         wait_resp <= 1'b1;
         wait_cnt <= '0;
      end else if (wait_resp) begin
         wait_cnt <= wait_cnt + 8'd1;
      end
   end

   a_reset_quiet: assert property (@(posedge clkrst_mem_clk)
      !clkrst_mem_rst_n |-> !resp_valid && !ptw2arb_valid && !tlb2ptw_done &&
                            !s_bvalid && !s_rvalid)
      else $error("valid output high during reset");

   a_arb_hold: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      ptw2arb_valid && ptw2arb_stall |=> ptw2arb_valid && $stable(ptw2arb_addr))
      else $error("arbiter request changed while stalled");

   a_resp_in_time: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      wait_cnt < 8'd64)
      else $error("no lookup response within 64 cycles");

   a_resp_after_done: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      tlb2ptw_done |=> resp_valid)
      else $error("resp_valid did not follow walker completion");

   a_b_hold: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
      else $error("write response dropped before bready");

   a_r_hold: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp))
      else $error("read response changed before rready");

endmodule

bind mmu_top tb_mmu_chk u_chk (.*);

/* test/tb_atom_mem.sv */
`timescale 1ns/10ps

module tb_atom_mem (
   input  logic                     clkrst_mem_clk,
   input  logic                     clkrst_mem_rst_n,
   input  logic                     ptw2arb_valid,
   input  mem_atom_pkg::atom_addr_t ptw2arb_addr,
   output mem_atom_pkg::atom_data_t ptw2arb_rdata,
   output logic                     ptw2arb_rvalid,
   output logic                     ptw2arb_stall
);

   integer seed;
   logic acc_q;
   mem_atom_pkg::atom_addr_t addr_q;

   // Directory at page 0x00100
   function automatic logic [31:0] dir_entry(input logic [9:0] d);
      if (d[1:0] == 2'd3) begin
         return 32'h0;
      end else if (d[1:0] == 2'd2) begin
         // Large page with bit 7 set
         return {d ^ 10'h2aa, 10'h000, 12'h083};
      end
      return {20'h00200 + {10'h000, d}, 12'h007};
   endfunction

   function automatic logic [31:0] tab_entry(input logic [9:0] d, input logic [9:0] t);
      logic [19:0] ppn;
      if (t[2:0] == 3'd7) begin
         return 32'h0;
      end
      ppn = {d, 10'h000} + {10'h000, t} + 20'h12345;
      return {ppn, 12'h003};
   endfunction

   function automatic mem_atom_pkg::atom_data_t atom_at(input mem_atom_pkg::atom_addr_t a);
      mem_atom_pkg::atom_data_t data;
      logic [19:0] page;
      logic [9:0] idx;
      page = a[26:7];
      for (int i = 0; i < 8; i++) begin
         idx = {a[6:0], 3'(i)};
         if (page == 20'h00100) begin
            data[i*32 +: 32] = dir_entry(idx);
         end else if (page >= 20'h00200 && page < 20'h00600) begin
            data[i*32 +: 32] = tab_entry(10'(page - 20'h00200), idx);
         end else begin
            // Unmapped pages read as non-present entries
            data[i*32 +: 32] = {a, 3'(i), 2'b00};
         end
      end
      return data;
   endfunction

   initial begin
      seed = 32'hfc6d_3475;
      acc_q = 1'b0;
      addr_q = '0;
      ptw2arb_rdata = '0;
      ptw2arb_rvalid = 1'b0;
      ptw2arb_stall = 1'b0;
   end

   // Data returns two cycles after the request is taken
   always @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         acc_q <= 1'b0;
         ptw2arb_rvalid <= 1'b0;
         ptw2arb_stall <= 1'b0;
      end else begin
         ptw2arb_stall <= (($random(seed) & 32'd3) == 32'd0);
         acc_q <= ptw2arb_valid && !ptw2arb_stall;
         if (ptw2arb_valid && !ptw2arb_stall) begin
            addr_q <= ptw2arb_addr;
         end
         ptw2arb_rvalid <= acc_q;
         if (acc_q) begin
            ptw2arb_rdata <= atom_at(addr_q);
         end
      end
   end

endmodule

/* test/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen (
   output logic clkrst_mem_clk,
   output logic clkrst_mem_rst_n
);

   // 100 ns period
   initial begin
      clkrst_mem_clk = 1'b0;
      forever #50 clkrst_mem_clk = ~clkrst_mem_clk;
   end

   // Reset held for the first 8 rising edges
   initial begin
      clkrst_mem_rst_n = 1'b0;
      repeat (8) @(posedge clkrst_mem_clk);
      clkrst_mem_rst_n <= 1'b1;
   end

endmodule

/* logic/mmu_top.sv */
`timescale 1ns/10ps

module mmu_top #(
   parameter int TLB_ENTRIES = 4,
   parameter int CSR_ADDR_W = 4
) (
   input  logic                     clkrst_mem_clk,
   input  logic                     clkrst_mem_rst_n,
   // Core lookup port
   input  logic                     lookup_valid,
   input  mmu_pkg::vpn_t            lookup_vpn,
   output logic                     lookup_ready,
   output logic                     resp_valid,
   output logic                     resp_fault,
   output mmu_pkg::ppn_t            resp_ppn,
   output mmu_pkg::pte_flags_t      resp_flags,
   // AXI4-Lite register port
   input  logic [CSR_ADDR_W-1:0]    s_awaddr,
   input  logic                     s_awvalid,
   output logic                     s_awready,
   input  logic [31:0]              s_wdata,
   input  logic [3:0]               s_wstrb,
   input  logic                     s_wvalid,
   output logic                     s_wready,
   output logic                     s_bvalid,
   output logic [1:0]               s_bresp,
   input  logic                     s_bready,
   input  logic [CSR_ADDR_W-1:0]    s_araddr,
   input  logic                     s_arvalid,
   output logic                     s_arready,
   output logic                     s_rvalid,
   output logic [1:0]               s_rresp,
   output logic [31:0]              s_rdata,
   input  logic                     s_rready,
   // Cache arbiter read port
   output logic                     ptw2arb_valid,
   output mem_atom_pkg::arb_opc_t   ptw2arb_opcode,
   output mem_atom_pkg::atom_addr_t ptw2arb_addr,
   input  mem_atom_pkg::atom_data_t ptw2arb_rdata,
   input  logic                     ptw2arb_rvalid,
   input  logic                     ptw2arb_stall
);

   mmu_pkg::ppn_t pagedir_base;
   logic tlb_flush;
   logic tlb2ptw_re;
   logic tlb2ptw_ready;
   logic tlb2ptw_done;
   mmu_pkg::vpn_t tlb2ptw_addr;
   mmu_pkg::ppn_t tlb2ptw_phys_addr;
   mmu_pkg::pte_flags_t tlb2ptw_pagedir_flags;
   mmu_pkg::pte_flags_t tlb2ptw_pagetab_flags;

   mmu_ctrl_regs #(
      .CSR_ADDR_W(CSR_ADDR_W)
   ) u_regs (
      .clkrst_mem_clk, .clkrst_mem_rst_n,
      .s_awaddr, .s_awvalid, .s_awready,
      .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
      .s_bvalid, .s_bresp, .s_bready,
      .s_araddr, .s_arvalid, .s_arready,
      .s_rvalid, .s_rresp, .s_rdata, .s_rready,
      .pagedir_base, .tlb_flush
   );

   mmu_tlb #(
      .TLB_ENTRIES(TLB_ENTRIES)
   ) u_tlb (
      .clkrst_mem_clk, .clkrst_mem_rst_n,
      .lookup_valid, .lookup_vpn, .lookup_ready,
      .resp_valid, .resp_fault, .resp_ppn, .resp_flags,
      .tlb_flush,
      .tlb2ptw_re, .tlb2ptw_addr, .tlb2ptw_ready, .tlb2ptw_done,
      .tlb2ptw_phys_addr, .tlb2ptw_pagedir_flags, .tlb2ptw_pagetab_flags
   );

   mmu_pt_walk u_walk (
      .clkrst_mem_clk, .clkrst_mem_rst_n,
      .tlb2ptw_addr, .tlb2ptw_re,
      .ptw_pagedir_base(pagedir_base),
      .tlb2ptw_phys_addr, .tlb2ptw_ready, .tlb2ptw_done,
      .tlb2ptw_pagetab_flags, .tlb2ptw_pagedir_flags,
      .ptw2arb_valid, .ptw2arb_opcode, .ptw2arb_addr,
      .ptw2arb_rdata, .ptw2arb_rvalid, .ptw2arb_stall
   );

endmodule

/* logic/mmu_pt_walk.sv */
`timescale 1ns/10ps

module mmu_pt_walk (
   input  logic                     clkrst_mem_clk,
   input  logic                     clkrst_mem_rst_n,
   input  mmu_pkg::vpn_t            tlb2ptw_addr,
   input  logic                     tlb2ptw_re,
   input  mmu_pkg::ppn_t            ptw_pagedir_base,
   output mmu_pkg::ppn_t            tlb2ptw_phys_addr,
   output logic                     tlb2ptw_ready,
   output logic                     tlb2ptw_done,
   output mmu_pkg::pte_flags_t      tlb2ptw_pagetab_flags,
   output mmu_pkg::pte_flags_t      tlb2ptw_pagedir_flags,
   output logic                     ptw2arb_valid,
   output mem_atom_pkg::arb_opc_t   ptw2arb_opcode,
   output mem_atom_pkg::atom_addr_t ptw2arb_addr,
   input  mem_atom_pkg::atom_data_t ptw2arb_rdata,
   input  logic                     ptw2arb_rvalid,
   input  logic                     ptw2arb_stall
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ_DIR,
      ST_READ_TAB
   } walk_state_t;

   walk_state_t state;
   mmu_pkg::vpn_t vpn_q;
   mmu_pkg::pte_t pde;
   mmu_pkg::pte_t pte;
   logic pde_present;
   logic pde_large;

   // vpn[19:10] indexes the directory, vpn[9:0] the table
   // Low three index bits pick one of the eight entries in an atom
   assign pde = ptw2arb_rdata[{vpn_q[12:10], 5'b00000} +: 32];
   assign pte = ptw2arb_rdata[{vpn_q[2:0], 5'b00000} +: 32];
   assign pde_present = pde[mmu_pkg::FLAG_PRESENT];
   assign pde_large = pde[mmu_pkg::PDE_LARGE_BIT];

   assign tlb2ptw_ready = (state == ST_IDLE);
   // Walker only ever reads
   assign ptw2arb_opcode = mem_atom_pkg::ARB_OPC_READ;

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         state <= ST_IDLE;
         ptw2arb_valid <= 1'b0;
         tlb2ptw_done <= 1'b0;
      end else begin
         tlb2ptw_done <= 1'b0;
         // Request drops once the arbiter takes it
         if (ptw2arb_valid && !ptw2arb_stall) begin
            ptw2arb_valid <= 1'b0;
         end
         case (state)
            ST_IDLE: begin
               if (tlb2ptw_re) begin
                  ptw2arb_valid <= 1'b1;
                  state <= ST_READ_DIR;
               end
            end
            ST_READ_DIR: begin
               if (ptw2arb_rvalid) begin
                  if (!pde_present || pde_large) begin
                     tlb2ptw_done <= 1'b1;
                     state <= ST_IDLE;
                  end else begin
                     ptw2arb_valid <= 1'b1;
                     state <= ST_READ_TAB;
                  end
               end
            end
            ST_READ_TAB: begin
               if (ptw2arb_rvalid) begin
                  tlb2ptw_done <= 1'b1;
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clkrst_mem_clk) begin
      if (state == ST_IDLE && tlb2ptw_re) begin
         vpn_q <= tlb2ptw_addr;
         ptw2arb_addr <= {ptw_pagedir_base, tlb2ptw_addr[19:13]};
      end
      if (state == ST_READ_DIR && ptw2arb_rvalid) begin
         tlb2ptw_pagedir_flags <= pde[3:0];
         ptw2arb_addr <= {pde[31:12], vpn_q[9:3]};
         if (pde_present && pde_large) begin
            // 4 MiB page, directory flags stand in for the table's
            tlb2ptw_pagetab_flags <= pde[3:0];
            tlb2ptw_phys_addr <= {pde[31:22], vpn_q[9:0]};
         end else begin
            // Zero means the table entry was not read
            tlb2ptw_pagetab_flags <= '0;
         end
      end
      if (state == ST_READ_TAB && ptw2arb_rvalid) begin
         tlb2ptw_pagetab_flags <= pte[3:0];
         tlb2ptw_phys_addr <= pte[31:12];
      end
   end

endmodule

/* logic/mmu_tlb.sv */
`timescale 1ns/10ps

module mmu_tlb #(
   parameter int TLB_ENTRIES = 4
) (
   input  logic                clkrst_mem_clk,
   input  logic                clkrst_mem_rst_n,
   input  logic                lookup_valid,
   input  mmu_pkg::vpn_t       lookup_vpn,
   output logic                lookup_ready,
   output logic                resp_valid,
   output logic                resp_fault,
   output mmu_pkg::ppn_t       resp_ppn,
   output mmu_pkg::pte_flags_t resp_flags,
   input  logic                tlb_flush,
   output logic                tlb2ptw_re,
   output mmu_pkg::vpn_t       tlb2ptw_addr,
   input  logic                tlb2ptw_ready,
   input  logic                tlb2ptw_done,
   input  mmu_pkg::ppn_t       tlb2ptw_phys_addr,
   input  mmu_pkg::pte_flags_t tlb2ptw_pagedir_flags,
   input  mmu_pkg::pte_flags_t tlb2ptw_pagetab_flags
);

   localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

   logic [TLB_ENTRIES-1:0] ent_valid;
   mmu_pkg::vpn_t ent_vpn [TLB_ENTRIES];
   mmu_pkg::ppn_t ent_ppn [TLB_ENTRIES];
   mmu_pkg::pte_flags_t ent_flags [TLB_ENTRIES];

   logic [IDX_W-1:0] victim;
   logic [IDX_W-1:0] hit_idx;
   logic hit;
   logic busy;
   logic accept;
   logic walk_req;
   logic walk_active;
   logic walk_flushed;
   logic walk_end;
   logic walk_fault;
   logic cache_fill;
   mmu_pkg::vpn_t miss_vpn;

   assign lookup_ready = !busy;
   assign accept = lookup_valid && lookup_ready;
   assign tlb2ptw_re = walk_req;
   assign tlb2ptw_addr = miss_vpn;

   // Walker reports flags only, the fault is worked out here
   assign walk_end = tlb2ptw_done && walk_active;
   assign walk_fault = !tlb2ptw_pagedir_flags[mmu_pkg::FLAG_PRESENT] ||
                       !tlb2ptw_pagetab_flags[mmu_pkg::FLAG_PRESENT];
   // A flush seen during the walk keeps its result out of the cache
   assign cache_fill = walk_end && !walk_fault && !walk_flushed && !tlb_flush;

   always_comb begin
      hit = 1'b0;
      hit_idx = '0;
      for (int i = 0; i < TLB_ENTRIES; i++) begin
         if (ent_valid[i] && ent_vpn[i] == lookup_vpn) begin
            hit = 1'b1;
            hit_idx = IDX_W'(i);
         end
      end
   end

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         busy <= 1'b0;
         resp_valid <= 1'b0;
         walk_req <= 1'b0;
         walk_active <= 1'b0;
         walk_flushed <= 1'b0;
         ent_valid <= '0;
         victim <= '0;
      end else begin
         resp_valid <= 1'b0;
         if (resp_valid) begin
            busy <= 1'b0;
         end
         if (accept) begin
            busy <= 1'b1;
            if (hit) begin
               resp_valid <= 1'b1;
            end else begin
               walk_req <= 1'b1;
               walk_active <= 1'b1;
               walk_flushed <= 1'b0;
            end
         end
         if (walk_req && tlb2ptw_ready) begin
            walk_req <= 1'b0;
         end
         if (walk_end) begin
            walk_active <= 1'b0;
            resp_valid <= 1'b1;
         end
         if (cache_fill) begin
            ent_valid[victim] <= 1'b1;
            victim <= (victim == IDX_W'(TLB_ENTRIES - 1)) ? '0 : victim + 1'b1;
         end
         if (tlb_flush) begin
            ent_valid <= '0;
            if (walk_active) walk_flushed <= 1'b1;
         end
      end
   end

   always_ff @(posedge clkrst_mem_clk) begin
      if (accept) begin
         miss_vpn <= lookup_vpn;
         resp_ppn <= ent_ppn[hit_idx];
         resp_flags <= ent_flags[hit_idx];
         resp_fault <= 1'b0;
      end
      if (walk_end) begin
         resp_ppn <= tlb2ptw_phys_addr;
         resp_flags <= tlb2ptw_pagetab_flags;
         resp_fault <= walk_fault;
      end
      if (cache_fill) begin
         ent_vpn[victim] <= miss_vpn;
         ent_ppn[victim] <= tlb2ptw_phys_addr;
         ent_flags[victim] <= tlb2ptw_pagetab_flags;
      end
   end

endmodule

/* logic/mmu_ctrl_regs.sv */
`timescale 1ns/10ps

module mmu_ctrl_regs #(
   parameter int CSR_ADDR_W = 4
) (
   input  logic                  clkrst_mem_clk,
   input  logic                  clkrst_mem_rst_n,
   input  logic [CSR_ADDR_W-1:0] s_awaddr,
   input  logic                  s_awvalid,
   output logic                  s_awready,
   input  logic [31:0]           s_wdata,
   input  logic [3:0]            s_wstrb,
   input  logic                  s_wvalid,
   output logic                  s_wready,
   output logic                  s_bvalid,
   output logic [1:0]            s_bresp,
   input  logic                  s_bready,
   input  logic [CSR_ADDR_W-1:0] s_araddr,
   input  logic                  s_arvalid,
   output logic                  s_arready,
   output logic                  s_rvalid,
   output logic [1:0]            s_rresp,
   output logic [31:0]           s_rdata,
   input  logic                  s_rready,
   output mmu_pkg::ppn_t         pagedir_base,
   output logic                  tlb_flush
);

   typedef enum logic [1:0] {
      W_IDLE,
      W_HAVE_ADDR,
      W_HAVE_DATA,
      W_RESP
   } wr_state_t;

   localparam logic [1:0] RESP_OKAY = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   wr_state_t wr_state;
   logic [CSR_ADDR_W-1:0] awaddr_q;
   logic [31:0] wdata_q;
   logic [3:0] wstrb_q;
   logic aw_fire;
   logic w_fire;
   logic wr_go;
   logic [CSR_ADDR_W-1:0] wr_addr;
   logic [31:0] wr_data;
   logic [3:0] wr_strb;

   // Address and data may come in either order
   assign s_awready = s_awvalid && (wr_state == W_IDLE || wr_state == W_HAVE_DATA);
   assign s_wready = s_wvalid && (wr_state == W_IDLE || wr_state == W_HAVE_ADDR);
   assign s_bvalid = (wr_state == W_RESP);
   assign s_arready = s_arvalid && !s_rvalid;

   assign aw_fire = s_awvalid && s_awready;
   assign w_fire = s_wvalid && s_wready;
   assign wr_go = (wr_state == W_IDLE && aw_fire && w_fire) ||
                  (wr_state == W_HAVE_ADDR && w_fire) ||
                  (wr_state == W_HAVE_DATA && aw_fire);

   assign wr_addr = aw_fire ? s_awaddr : awaddr_q;
   assign wr_data = w_fire ? s_wdata : wdata_q;
   assign wr_strb = w_fire ? s_wstrb : wstrb_q;

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         wr_state <= W_IDLE;
         s_rvalid <= 1'b0;
         pagedir_base <= '0;
         tlb_flush <= 1'b0;
      end else begin
         tlb_flush <= 1'b0;
         case (wr_state)
            W_IDLE: begin
               if (aw_fire && !w_fire) begin
                  wr_state <= W_HAVE_ADDR;
               end else if (w_fire && !aw_fire) begin
                  wr_state <= W_HAVE_DATA;
               end
            end
            W_RESP: begin
               if (s_bready) begin
                  wr_state <= W_IDLE;
               end
            end
            default: ;
         endcase
         if (wr_go) begin
            wr_state <= W_RESP;
            if (wr_addr == CSR_ADDR_W'(0)) begin
               if (wr_strb[0]) pagedir_base[7:0] <= wr_data[7:0];
               if (wr_strb[1]) pagedir_base[15:8] <= wr_data[15:8];
               if (wr_strb[2]) pagedir_base[19:16] <= wr_data[19:16];
            end else if (wr_addr == CSR_ADDR_W'(4)) begin
               tlb_flush <= wr_strb[0] && wr_data[0];
            end
         end
         if (s_arvalid && s_arready) begin
            s_rvalid <= 1'b1;
         end else if (s_rready) begin
            s_rvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clkrst_mem_clk) begin
      if (aw_fire) awaddr_q <= s_awaddr;
      if (w_fire) begin
         wdata_q <= s_wdata;
         wstrb_q <= s_wstrb;
      end
      if (wr_go) begin
         s_bresp <= (wr_addr == CSR_ADDR_W'(0) || wr_addr == CSR_ADDR_W'(4)) ?
                    RESP_OKAY : RESP_SLVERR;
      end
      if (s_arvalid && s_arready) begin
         // Flush register is write-only and reads as zero
         s_rdata <= (s_araddr == CSR_ADDR_W'(0)) ? {12'h000, pagedir_base} : 32'h0;
         s_rresp <= (s_araddr == CSR_ADDR_W'(0) || s_araddr == CSR_ADDR_W'(4)) ?
                    RESP_OKAY : RESP_SLVERR;
      end
   end

endmodule

/* logic/mem_atom_pkg.sv */
package mem_atom_pkg;

   // One atom is 32 bytes, eight page-table entries
   typedef logic [255:0] atom_data_t;

   // Atom address, byte address bits 31 down to 5
   typedef logic [26:0] atom_addr_t;

   // Arbiter request opcode
   typedef logic [2:0] arb_opc_t;

   localparam arb_opc_t ARB_OPC_READ = 3'b001;

endpackage

/* logic/mmu_pkg.sv */
package mmu_pkg;

   // Page numbers for 4 KiB pages in a 32-bit address space
   typedef logic [19:0] vpn_t;
   typedef logic [19:0] ppn_t;

   // Low flag nibble of a directory or table entry
   typedef logic [3:0] pte_flags_t;

   // One page directory or page table entry
   typedef logic [31:0] pte_t;

   // Flag bit that marks an entry as present
   localparam int FLAG_PRESENT = 0;

   // Directory entry maps a 4 MiB page directly when set
   localparam int PDE_LARGE_BIT = 7;

endpackage
